// File: test/nibble_testdata.txt
// instr_dst_val_wr_flags in hex, one instruction per line, PC counts up from 000
// dst 0..3 is A, B, M(X), M(Y); flags are D, unused, Z, C from bit 3 down
E07_0_7_1_0  // LD A,7
E19_1_9_1_0  // LD B,9
E24_2_4_1_0  // LD M(X),4
E3B_3_B_1_0  // LD M(Y),B
A81_0_0_1_3  // ADD A,B       7+9 wraps to 0
A84_1_9_1_0  // ADD B,A
A82_0_4_1_0  // ADD A,M(X)
A88_2_8_1_0  // ADD M(X),A
A8E_3_3_1_1  // ADD M(Y),M(X) B+8 carries
A87_1_C_1_0  // ADD B,M(Y)
C09_0_D_1_0  // ADD A,9
C29_2_1_1_1  // ADD M(X),9
F48_0_8_0_9  // SET F,8       decimal on
E06_0_6_1_9  // LD A,6
E14_1_4_1_9  // LD B,4
A81_0_0_1_B  // ADD A,B       6+4 wraps at ten
C09_0_9_1_8  // ADD A,9
A88_2_0_1_B  // ADD M(X),A    1+9 wraps at ten
C39_3_2_1_9  // ADD M(Y),9
A87_1_6_1_8  // ADD B,M(Y)
F57_0_7_0_0  // RST F,7       decimal off
A81_0_F_1_0  // ADD A,B       binary again
FFF_F_F_F_F  // End of list

// File: tb.f
+incdir+common
common/nibble_pkg.sv
core/decimal_adder.sv
core/wb_master.sv
core/reg_file.sv
core/exec_sequencer.sv
core/nibble_core.sv
test/wb_mem_model.sv
test/tb_nibble_core.sv

// File: test/tb_nibble_core.sv
`default_nettype none

`include "nibble_config.svh"

module tb_nibble_core
  import nibble_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          MAX_RECS       = 64;
  localparam int          CYCLES_PER_REC = 40;
  localparam logic [31:0] RAND_SEED      = 32'ha99b_3344;
  localparam logic [27:0] END_MARK       = 28'hFFF_FFFF;

  logic                   clk;
  logic                   arst_n;
  logic                   ibus_cyc;
  logic                   ibus_stb;
  logic [`NIB_PC_W-1:0]   ibus_adr;
  instr_t                 ibus_dat_i;
  logic                   ibus_ack;
  logic                   dbus_cyc;
  logic                   dbus_stb;
  logic                   dbus_we;
  logic [`NIB_RAM_AW-1:0] dbus_adr;
  nibble_t                dbus_dat_o;
  nibble_t                dbus_dat_i;
  logic                   dbus_ack;
  logic                   retire;
  logic [`NIB_PC_W-1:0]   retire_pc;
  reg_sel_t               retire_dst;
  nibble_t                retire_val;
  logic                   retire_wr;
  flags_t                 retire_flags;

  logic [27:0]            records [0:MAX_RECS-1];   // instr, dst, val, wr, flags
  int                     num_recs;
  int                     cycle_limit;
  int                     cycles = 0;
  int                     wr_count = 0;
  logic [`NIB_RAM_AW-1:0] wr_adr;
  nibble_t                wr_dat;

  always #4 clk = ~clk;

  nibble_core UUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .ibus_cyc     (ibus_cyc),
    .ibus_stb     (ibus_stb),
    .ibus_adr     (ibus_adr),
    .ibus_dat_i   (ibus_dat_i),
    .ibus_ack     (ibus_ack),
    .dbus_cyc     (dbus_cyc),
    .dbus_stb     (dbus_stb),
    .dbus_we      (dbus_we),
    .dbus_adr     (dbus_adr),
    .dbus_dat_o   (dbus_dat_o),
    .dbus_dat_i   (dbus_dat_i),
    .dbus_ack     (dbus_ack),
    .retire       (retire),
    .retire_pc    (retire_pc),
    .retire_dst   (retire_dst),
    .retire_val   (retire_val),
    .retire_wr    (retire_wr),
    .retire_flags (retire_flags)
  );

  wb_mem_model #(
    .ADR_W (`NIB_PC_W),
    .DAT_W (`NIB_INSTR_W),
    .SEED  (RAND_SEED)
  ) u_rom (
    .clk    (clk),
    .arst_n (arst_n),
    .cyc    (ibus_cyc),
    .stb    (ibus_stb),
    .we     (1'b0),
    .adr    (ibus_adr),
    .dat_i  ('0),
    .dat_o  (ibus_dat_i),
    .ack    (ibus_ack)
  );

  wb_mem_model #(
    .ADR_W (`NIB_RAM_AW),
    .DAT_W (4),
    .SEED  (RAND_SEED)
  ) u_ram (
    .clk    (clk),
    .arst_n (arst_n),
    .cyc    (dbus_cyc),
    .stb    (dbus_stb),
    .we     (dbus_we),
    .adr    (dbus_adr),
    .dat_i  (dbus_dat_o),
    .dat_o  (dbus_dat_i),
    .ack    (dbus_ack)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_nibble(input string name, input nibble_t got, input nibble_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_sel(input string name, input reg_sel_t got, input reg_sel_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flags(input string name, input flags_t got, input flags_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pc(input string name, input logic [`NIB_PC_W-1:0] got,
                          input logic [`NIB_PC_W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_adr(input string name, input logic [`NIB_RAM_AW-1:0] got,
                           input logic [`NIB_RAM_AW-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // Last completed RAM write
  always @(negedge clk) begin
    if (dbus_cyc && dbus_stb && dbus_we && dbus_ack) begin
      wr_count <= wr_count + 1;
      wr_adr   <= dbus_adr;
      wr_dat   <= dbus_dat_o;
    end
  end

  always @(posedge clk) begin
    if (arst_n) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
        $display("Timeout after %0d cycles, the core stopped retiring instructions", cycles);
        abort_run();
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus and trace checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : run_tests
    int          i;
    int          exp_writes;
    logic [27:0] rec;
    clk        = 1'b0;
    arst_n     = 1'b0;
    exp_writes = 0;
    $readmemh("test/nibble_testdata.txt", records);
    num_recs = 0;
    while (num_recs < MAX_RECS && records[num_recs] !== END_MARK)
      num_recs++;
    if (num_recs == MAX_RECS) begin
      $display("The test data file has no end marker or could not be read");
      abort_run();
    end
    cycle_limit = CYCLES_PER_REC * num_recs;
    repeat (2) @(posedge clk);
    for (i = 0; i < num_recs; i++)
      u_rom.mem[i] = records[i][27:16];   // Program sits at PC 000 up
    repeat (6) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_bit("ibus_cyc", ibus_cyc, 1'b0);
    check_bit("ibus_stb", ibus_stb, 1'b0);
    check_bit("dbus_cyc", dbus_cyc, 1'b0);
    check_bit("dbus_stb", dbus_stb, 1'b0);
    check_bit("dbus_we", dbus_we, 1'b0);
    check_bit("retire", retire, 1'b0);
    while (!ibus_cyc)
      @(negedge clk);
    check_pc("ibus_adr", ibus_adr, '0);
    check_bit("retire", retire, 1'b0);
    for (i = 0; i < num_recs; i++) begin
      while (!retire)
        @(negedge clk);
      rec = records[i];
      check_pc("retire_pc", retire_pc, `NIB_PC_W'(i));
      check_sel("retire_dst", retire_dst, reg_sel_t'(rec[13:12]));
      check_nibble("retire_val", retire_val, rec[11:8]);
      check_bit("retire_wr", retire_wr, rec[4]);
      check_flags("retire_flags", retire_flags, flags_t'(rec[3:0]));
      if (rec[4] && rec[13]) begin   // M(X) or M(Y) result
        exp_writes++;
        check_adr("dbus_adr", wr_adr, rec[12] ? `NIB_Y_RESET : `NIB_X_RESET);
        check_nibble("dbus_dat_o", wr_dat, rec[11:8]);
      end
      check_count("dbus write count", wr_count, exp_writes);
      @(negedge clk);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/wb_mem_model.sv
`default_nettype none

module wb_mem_model #(
  parameter int          ADR_W = 8,
  parameter int          DAT_W = 4,
  parameter logic [31:0] SEED  = 32'h1
) (
  input  wire              clk,
  input  wire              arst_n,
  input  wire              cyc,
  input  wire              stb,
  input  wire              we,
  input  wire [ADR_W-1:0]  adr,
  input  wire [DAT_W-1:0]  dat_i,
  output logic [DAT_W-1:0] dat_o,
  output logic             ack
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [DAT_W-1:0] mem [0:(1<<ADR_W)-1];
  integer           seed;
  logic [31:0]      rnd;
  logic [1:0]       left;       // Wait cycles still to go
  logic [1:0]       wait_cnt;
  logic             pending;

  initial begin
    seed = SEED;
    for (int i = 0; i < (1 << ADR_W); i++)
      mem[i] = DAT_W'((i * 32'h9E37_79B1) >> (32 - DAT_W));   // Hash of the address
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Classic slave, 0 to 3 wait cycles per transfer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack      <= 1'b0;
      pending  <= 1'b0;
      wait_cnt <= 2'd0;
    end else begin
      ack <= 1'b0;
      if (cyc && stb && !ack) begin
        if (!pending) begin
          rnd     = $random(seed);   // New delay per transfer
          left    = rnd[1:0];
          pending <= 1'b1;
        end else begin
          left = wait_cnt;
        end
        if (left == 2'd0) begin
          ack     <= 1'b1;
          pending <= 1'b0;
          if (we)
            mem[adr] <= dat_i;
          else
            dat_o <= mem[adr];
        end else begin
          wait_cnt <= left - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: core/nibble_core.sv
`default_nettype none

`include "nibble_config.svh"

module nibble_core
  import nibble_pkg::*;
(
  input  wire                     clk,
  input  wire                     arst_n,
  // Instruction fetch bus
  output logic                    ibus_cyc,
  output logic                    ibus_stb,
  output logic [`NIB_PC_W-1:0]    ibus_adr,
  input  wire instr_t             ibus_dat_i,
  input  wire                     ibus_ack,
  // Data RAM bus
  output logic                    dbus_cyc,
  output logic                    dbus_stb,
  output logic                    dbus_we,
  output logic [`NIB_RAM_AW-1:0]  dbus_adr,
  output nibble_t                 dbus_dat_o,
  input  wire nibble_t            dbus_dat_i,
  input  wire                     dbus_ack,
  // Trace
  output logic                    retire,
  output logic [`NIB_PC_W-1:0]    retire_pc,
  output reg_sel_t                retire_dst,
  output nibble_t                 retire_val,
  output logic                    retire_wr,
  output flags_t                  retire_flags
);

  logic [`NIB_PC_W-1:0]   pc;
  logic [`NIB_RAM_AW-1:0] reg_x;
  logic [`NIB_RAM_AW-1:0] reg_y;
  nibble_t                reg_a;
  nibble_t                reg_b;
  flags_t                 flags;

  logic                   ifetch_start;
  logic                   ifetch_done;
  logic [`NIB_PC_W-1:0]   ifetch_adr;
  instr_t                 ifetch_data;
  logic                   dmem_start;
  logic                   dmem_done;
  logic                   dmem_we;
  logic [`NIB_RAM_AW-1:0] dmem_adr;
  nibble_t                dmem_wdata;
  nibble_t                dmem_rdata;

  nibble_t                add_a;
  nibble_t                add_b;
  nibble_t                sum;
  logic                   sum_carry;
  logic                   sum_zero;

  logic                   wr_en;
  reg_sel_t               wr_dst;
  nibble_t                wr_val;
  logic                   flags_wr;
  flags_t                 flags_next;
  logic                   pc_inc;

  exec_sequencer u_seq (
    .clk          (clk),
    .arst_n       (arst_n),
    .pc           (pc),
    .reg_a        (reg_a),
    .reg_b        (reg_b),
    .reg_x        (reg_x),
    .reg_y        (reg_y),
    .flags        (flags),
    .ifetch_done  (ifetch_done),
    .ifetch_data  (ifetch_data),
    .dmem_done    (dmem_done),
    .dmem_rdata   (dmem_rdata),
    .sum          (sum),
    .sum_carry    (sum_carry),
    .sum_zero     (sum_zero),
    .ifetch_start (ifetch_start),
    .ifetch_adr   (ifetch_adr),
    .dmem_start   (dmem_start),
    .dmem_we      (dmem_we),
    .dmem_adr     (dmem_adr),
    .dmem_wdata   (dmem_wdata),
    .add_a        (add_a),
    .add_b        (add_b),
    .wr_en        (wr_en),
    .wr_dst       (wr_dst),
    .wr_val       (wr_val),
    .flags_wr     (flags_wr),
    .flags_next   (flags_next),
    .pc_inc       (pc_inc),
    .retire       (retire),
    .retire_pc    (retire_pc),
    .retire_dst   (retire_dst),
    .retire_val   (retire_val),
    .retire_wr    (retire_wr),
    .retire_flags (retire_flags)
  );

  reg_file u_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_dst     (wr_dst),
    .wr_val     (wr_val),
    .flags_wr   (flags_wr),
    .flags_next (flags_next),
    .pc_inc     (pc_inc),
    .pc         (pc),
    .reg_a      (reg_a),
    .reg_b      (reg_b),
    .reg_x      (reg_x),
    .reg_y      (reg_y),
    .sp         (),
    .flags      (flags)
  );

  decimal_adder u_adder (
    .a       (add_a),
    .b       (add_b),
    .decimal (flags.decimal),
    .sum     (sum),
    .carry   (sum_carry),
    .zero    (sum_zero)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus masters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  wb_master #(
    .ADR_W     (`NIB_PC_W),
    .payload_t (instr_t)
  ) u_ibus (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (ifetch_start),
    .we        (1'b0),          // Read only
    .adr       (ifetch_adr),
    .wdata     ('0),
    .done      (ifetch_done),
    .rdata     (ifetch_data),
    .cyc       (ibus_cyc),
    .stb       (ibus_stb),
    .bus_we    (),
    .bus_adr   (ibus_adr),
    .bus_dat_o (),
    .bus_dat_i (ibus_dat_i),
    .ack       (ibus_ack)
  );

  wb_master #(
    .ADR_W     (`NIB_RAM_AW),
    .payload_t (nibble_t)
  ) u_dbus (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (dmem_start),
    .we        (dmem_we),
    .adr       (dmem_adr),
    .wdata     (dmem_wdata),
    .done      (dmem_done),
    .rdata     (dmem_rdata),
    .cyc       (dbus_cyc),
    .stb       (dbus_stb),
    .bus_we    (dbus_we),
    .bus_adr   (dbus_adr),
    .bus_dat_o (dbus_dat_o),
    .bus_dat_i (dbus_dat_i),
    .ack       (dbus_ack)
  );

endmodule

`default_nettype wire

// File: core/exec_sequencer.sv
`default_nettype none

`include "nibble_config.svh"

module exec_sequencer
  import nibble_pkg::*;
(
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire [`NIB_PC_W-1:0]     pc,
  input  wire nibble_t            reg_a,
  input  wire nibble_t            reg_b,
  input  wire [`NIB_RAM_AW-1:0]   reg_x,
  input  wire [`NIB_RAM_AW-1:0]   reg_y,
  input  wire flags_t             flags,
  input  wire                     ifetch_done,
  input  wire instr_t             ifetch_data,
  input  wire                     dmem_done,
  input  wire nibble_t            dmem_rdata,
  input  wire nibble_t            sum,
  input  wire                     sum_carry,
  input  wire                     sum_zero,
  output logic                    ifetch_start,
  output logic [`NIB_PC_W-1:0]    ifetch_adr,
  output logic                    dmem_start,
  output logic                    dmem_we,
  output logic [`NIB_RAM_AW-1:0]  dmem_adr,
  output nibble_t                 dmem_wdata,
  output nibble_t                 add_a,
  output nibble_t                 add_b,
  output logic                    wr_en,
  output reg_sel_t                wr_dst,
  output nibble_t                 wr_val,
  output logic                    flags_wr,
  output flags_t                  flags_next,
  output logic                    pc_inc,
  output logic                    retire,
  output logic [`NIB_PC_W-1:0]    retire_pc,
  output reg_sel_t                retire_dst,
  output nibble_t                 retire_val,
  output logic                    retire_wr,
  output flags_t                  retire_flags
);

  seq_state_t   state;
  seq_state_t   state_next;
  logic         bus_wait;   // Request issued, waiting for done
  instr_t       instr;
  instr_class_t cls;
  reg_sel_t     r_sel;
  reg_sel_t     q_sel;
  reg_sel_t     mem_sel;
  nibble_t      imm;
  nibble_t      r_mem;
  nibble_t      q_mem;
  nibble_t      op_r;
  nibble_t      op_q;
  nibble_t      result;
  logic         writes_r;
  logic         r_is_mem;
  logic         r_reads_mem;
  logic         q_is_mem;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    cls = cls_nop;   // Anything unmatched retires as a no-op
    if (instr[11:4] == `NIB_OPC_ADD_RQ)
      cls = cls_add_rq;
    else if (instr[11:8] == `NIB_OPC_ADD_RI && instr[7:6] == 2'b00)
      cls = cls_add_ri;
    else if (instr[11:8] == `NIB_OPC_LD_RI && instr[7:6] == 2'b00)
      cls = cls_ld_ri;
    else if (instr[11:8] == `NIB_OPC_FLAG && instr[7:4] == `NIB_FLAG_SET)
      cls = cls_set_f;
    else if (instr[11:8] == `NIB_OPC_FLAG && instr[7:4] == `NIB_FLAG_RST)
      cls = cls_rst_f;
  end

  assign r_sel       = reg_sel_t'((cls == cls_add_rq) ? instr[3:2] : instr[5:4]);
  assign q_sel       = reg_sel_t'(instr[1:0]);
  assign imm         = instr[3:0];
  assign writes_r    = (cls == cls_add_rq) || (cls == cls_add_ri) || (cls == cls_ld_ri);
  assign r_is_mem    = r_sel[1];
  assign r_reads_mem = r_is_mem && ((cls == cls_add_rq) || (cls == cls_add_ri));
  assign q_is_mem    = (cls == cls_add_rq) && q_sel[1];

  // Operand muxes
  assign op_r  = (r_sel == sel_a) ? reg_a : (r_sel == sel_b) ? reg_b : r_mem;
  assign op_q  = (q_sel == sel_a) ? reg_a : (q_sel == sel_b) ? reg_b : q_mem;
  assign add_a = op_r;
  assign add_b = (cls == cls_add_rq) ? op_q : imm;

  always_comb begin
    result     = sum;
    flags_next = flags;
    case (cls)
      cls_add_rq, cls_add_ri: begin
        flags_next.zero  = sum_zero;
        flags_next.carry = sum_carry;
      end
      cls_ld_ri: result = imm;   // Flags untouched
      cls_set_f: flags_next = flags_t'(flags | imm);
      cls_rst_f: flags_next = flags_t'(flags & imm);
      default:   flags_next = flags;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Phase sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_next = state;
    case (state)
      st_fetch: if (ifetch_done) state_next = st_decode;
      st_decode: begin
        if (q_is_mem)
          state_next = st_read_q;
        else if (r_reads_mem)
          state_next = st_read_r;
        else
          state_next = st_exec;
      end
      st_read_q: if (dmem_done) state_next = r_reads_mem ? st_read_r : st_exec;
      st_read_r: if (dmem_done) state_next = st_exec;
      st_exec:   state_next = (writes_r && r_is_mem) ? st_write : st_retire;
      st_write:  if (dmem_done) state_next = st_retire;
      default:   state_next = st_fetch;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_fetch;
      bus_wait <= 1'b0;
    end else begin
      state <= state_next;
      if (ifetch_start || dmem_start)
        bus_wait <= 1'b1;
      else if (ifetch_done || dmem_done)
        bus_wait <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_fetch && ifetch_done) instr <= ifetch_data;
    if (state == st_read_q && dmem_done) q_mem <= dmem_rdata;
    if (state == st_read_r && dmem_done) r_mem <= dmem_rdata;
    if (state == st_exec) begin
      retire_dst   <= writes_r ? r_sel : sel_a;
      retire_val   <= writes_r ? result : imm;   // Flag ops report their mask
      retire_wr    <= writes_r;
      retire_flags <= flags_next;
    end
  end

  // Bus requests, one per phase
  assign ifetch_start = (state == st_fetch) && !bus_wait;
  assign ifetch_adr   = pc;
  assign dmem_start   = ((state == st_read_q) || (state == st_read_r) ||
                         (state == st_write)) && !bus_wait;
  assign dmem_we      = (state == st_write);
  assign mem_sel      = (state == st_read_q) ? q_sel : r_sel;
  assign dmem_adr     = (mem_sel == sel_mx) ? reg_x : reg_y;
  assign dmem_wdata   = retire_val;

  // Writeback and trace
  assign wr_en     = (state == st_exec) && writes_r;
  assign wr_dst    = r_sel;
  assign wr_val    = result;
  assign flags_wr  = (state == st_exec) && (cls != cls_ld_ri) && (cls != cls_nop);
  assign pc_inc    = (state == st_retire);
  assign retire    = (state == st_retire);
  assign retire_pc = pc;   // PC moves on after retire

endmodule

`default_nettype wire

// File: core/reg_file.sv
`default_nettype none

`include "nibble_config.svh"

module reg_file
  import nibble_pkg::*;
(
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     wr_en,
  input  wire reg_sel_t           wr_dst,
  input  wire nibble_t            wr_val,
  input  wire                     flags_wr,
  input  wire flags_t             flags_next,
  input  wire                     pc_inc,
  output logic [`NIB_PC_W-1:0]    pc,
  output nibble_t                 reg_a,
  output nibble_t                 reg_b,
  output logic [`NIB_RAM_AW-1:0]  reg_x,
  output logic [`NIB_RAM_AW-1:0]  reg_y,
  output logic [`NIB_RAM_AW-1:0]  sp,
  output flags_t                  flags
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Program counter and pointers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc    <= '0;
      reg_x <= `NIB_X_RESET;
      reg_y <= `NIB_Y_RESET;
      sp    <= '0;
    end else begin
      if (pc_inc)
        pc <= pc + 1'b1;   // Wraps at the top of ROM
    end
  end

  // Memory destinations go out over the data bus
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_a <= '0;
      reg_b <= '0;
    end else if (wr_en) begin
      case (wr_dst)
        sel_a:   reg_a <= wr_val;
        sel_b:   reg_b <= wr_val;
        default: reg_a <= reg_a;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      flags <= '0;
    else if (flags_wr)
      flags <= flags_next;
  end

endmodule

`default_nettype wire

// File: core/wb_master.sv
`default_nettype none

`include "nibble_config.svh"

module wb_master #(
  parameter int  ADR_W     = `NIB_RAM_AW,
  parameter type payload_t = logic [3:0]
) (
  input  wire              clk,
  input  wire              arst_n,
  input  wire              start,
  input  wire              we,
  input  wire [ADR_W-1:0]  adr,
  input  wire payload_t    wdata,
  output logic             done,
  output payload_t         rdata,
  output logic             cyc,
  output logic             stb,
  output logic             bus_we,
  output logic [ADR_W-1:0] bus_adr,
  output payload_t         bus_dat_o,
  input  wire payload_t    bus_dat_i,
  input  wire              ack
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Single classic cycle, held until ack
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cyc    <= 1'b0;
      bus_we <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !cyc) begin
        cyc    <= 1'b1;
        bus_we <= we;
      end else if (cyc && ack) begin
        cyc    <= 1'b0;   // Released the cycle after ack
        bus_we <= 1'b0;
        done   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && !cyc) begin
      bus_adr   <= adr;
      bus_dat_o <= wdata;
    end
    if (cyc && ack)
      rdata <= bus_dat_i;   // Valid with done
  end

  assign stb = cyc;

endmodule

`default_nettype wire

// File: core/decimal_adder.sv
`default_nettype none

module decimal_adder
  import nibble_pkg::*;
(
  input  wire nibble_t a,
  input  wire nibble_t b,
  input  wire          decimal,
  output nibble_t      sum,
  output logic         carry,
  output logic         zero
);

  logic [4:0] raw;
  logic [4:0] adj;

  assign raw = {1'b0, a} + {1'b0, b};
  assign adj = raw - 5'd10;

  always_comb begin
    if (decimal && raw >= 5'd10) begin
      sum   = adj[3:0];   // Wrap at ten
      carry = 1'b1;
    end else begin
      sum   = raw[3:0];
      carry = raw[4];
    end
  end

  assign zero = (sum == 4'h0);

endmodule

`default_nettype wire

// File: common/nibble_pkg.sv
`default_nettype none

`include "nibble_config.svh"

package nibble_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data words
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [3:0]              nibble_t;
  typedef logic [`NIB_INSTR_W-1:0] instr_t;

  // Operand selector, same encoding as the r and q fields
  typedef enum logic [1:0] {
    sel_a  = 2'd0,
    sel_b  = 2'd1,
    sel_mx = 2'd2,   // RAM at X
    sel_my = 2'd3    // RAM at Y
  } reg_sel_t;

  typedef enum logic [2:0] {
    cls_add_rq,
    cls_add_ri,
    cls_ld_ri,
    cls_set_f,
    cls_rst_f,
    cls_nop
  } instr_class_t;

  typedef struct packed {
    logic decimal;
    logic unused;
    logic zero;
    logic carry;
  } flags_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_read_q,
    st_read_r,
    st_exec,
    st_write,
    st_retire
  } seq_state_t;

endpackage

`default_nettype wire

// File: common/nibble_config.svh
`ifndef NIBBLE_CONFIG_SVH
`define NIBBLE_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and reset addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NIB_PC_W        12
`define NIB_RAM_AW      8
`define NIB_INSTR_W     12
`define NIB_X_RESET     8'h00
`define NIB_Y_RESET     8'h01

// Opcode prefixes, matched against the top of the word
`define NIB_OPC_ADD_RQ  8'hA8   // 1010 1000 rr qq
`define NIB_OPC_ADD_RI  4'hC    // 1100 00rr iiii
`define NIB_OPC_LD_RI   4'hE    // 1110 00rr iiii
`define NIB_OPC_FLAG    4'hF    // 1111 010x iiii
`define NIB_FLAG_SET    4'h4
`define NIB_FLAG_RST    4'h5

// Packed trace record: dst, val, wr, flags
`define NIB_TRACE_W     11

`endif
